/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_tg
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "^$(PASS_MSG)$$" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* hw/tg_page_boundary_addr_gen.sv */
// Page boundary address correction
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_page_boundary_addr_gen (
   input  tg_pkg::burstcount_t  burstcount,
   input  tg_pkg::addr_t        addr_in,
   output tg_pkg::addr_t        addr_out
);
   import tg_pkg::*;

   // Offset bits inside one page
   localparam int PAGE_BITS = $clog2(`TG_PAGE_WORDS);

   // Wide enough for the largest offset plus the largest length
   localparam int END_W = PAGE_BITS + `TG_BURSTCOUNT_WIDTH;

   localparam addr_t PAGE_MASK = addr_t'(`TG_PAGE_WORDS - 1);
   localparam addr_t PAGE_SIZE = addr_t'(`TG_PAGE_WORDS);

   logic [END_W-1:0] end_offset;
   logic             crosses;
   addr_t            next_page;

   // One past the last beat, relative to the page base
   assign end_offset = END_W'(addr_in[PAGE_BITS-1:0]) + END_W'(burstcount);

   // Last beat would land in the following page
   assign crosses = end_offset > END_W'(`TG_PAGE_WORDS);

   // Base of the following page wrapping at top of memory
   assign next_page = (addr_in & ~PAGE_MASK) + PAGE_SIZE;

   always_comb
   begin
      if (crosses)
         addr_out = next_page;
      else
         addr_out = addr_in;
   end

endmodule

/* hw/tg_pkg.sv */
// Traffic generator shared types
`include "tg_config.svh"

package tg_pkg;

   ////////////////////////////////////////////////////////////////////
   // Vectors with a meaning
   ////////////////////////////////////////////////////////////////////

   // Word address on the memory bus
   typedef logic [`TG_ADDR_WIDTH-1:0] addr_t;

   // One data word
   typedef logic [`TG_DATA_WIDTH-1:0] data_t;

   // Burst length in beats
   typedef logic [`TG_BURSTCOUNT_WIDTH-1:0] burstcount_t;

   // Saturating mismatch counter
   typedef logic [15:0] err_count_t;

   ////////////////////////////////////////////////////////////////////
   // Bus driver FSM
   ////////////////////////////////////////////////////////////////////
   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      WRITE,
      READ,
      DONE
   } drv_state_t;

endpackage

/* hw/tg_rand_burstcount_gen.sv */
// Random burst length generator
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_rand_burstcount_gen (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 enable,
   output logic                 ready,
   output tg_pkg::burstcount_t  burstcount
);
   import tg_pkg::*;

   // 16-bit Galois LFSR
   localparam int          LFSR_W = 16;
   localparam logic [15:0] TAPS   = 16'hB400;

   // Length range and the offset bits that cover it
   localparam int RANGE      = `TG_MAX_BURSTCOUNT - `TG_MIN_BURSTCOUNT + 1;
   localparam int RANGE_BITS = $clog2(RANGE);

   logic [LFSR_W-1:0] lfsr;
   logic [LFSR_W-1:0] lfsr_next;

   // Shift right and fold taps in when a one drops out
   assign lfsr_next = {1'b0, lfsr[LFSR_W-1:1]} ^ (lfsr[0] ? TAPS : '0);

   // Steps once per accepted burst
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         lfsr  <= `TG_LFSR_SEED;
         ready <= 1'b0;
      end
      else
      begin
         // Valid from the first edge out of reset
         ready <= 1'b1;
         if (enable && ready)
            lfsr <= lfsr_next;
      end
   end

   // Low bits of current value offset by the minimum
   assign burstcount = burstcount_t'(`TG_MIN_BURSTCOUNT)
                     + burstcount_t'(lfsr[RANGE_BITS-1:0]);

   // Low bits only map evenly onto a power-of-two range
   a_range_pow2 : assert property (@(posedge clk) (RANGE & (RANGE - 1)) == 0);

   // Offered length always inside the configured window
   a_len_in_range : assert property (@(posedge clk) disable iff (!reset_n)
      ready |-> (burstcount >= burstcount_t'(`TG_MIN_BURSTCOUNT)) &&
                (burstcount <= burstcount_t'(`TG_MAX_BURSTCOUNT)));

endmodule

/* hw/tg_seq_addr_gen.sv */
// Sequential start address generator
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_seq_addr_gen (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 enable,
   output logic                 ready,
   output tg_pkg::addr_t        addr,
   output tg_pkg::burstcount_t  burstcount
);
   import tg_pkg::*;

   localparam int PAGE_BITS = $clog2(`TG_PAGE_WORDS);
   localparam int END_W     = PAGE_BITS + `TG_BURSTCOUNT_WIDTH;

   // Proposed start before page correction
   addr_t            seq_addr;
   logic [END_W-1:0] burst_end;

   // Next proposal follows the burst just accepted
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
         seq_addr <= '0;
      else if (enable)
         seq_addr <= addr + addr_t'(burstcount);
   end

   // Length source stepping together with the address
   tg_rand_burstcount_gen u_rand_burstcount (
      .clk        (clk),
      .reset_n    (reset_n),
      .enable     (enable),
      .ready      (ready),
      .burstcount (burstcount)
   );

   // Pushes a straddling burst to the next page base
   tg_page_boundary_addr_gen u_page_boundary (
      .burstcount (burstcount),
      .addr_in    (seq_addr),
      .addr_out   (addr)
   );

   // Accepted burst stays inside one page
   assign burst_end = END_W'(addr[PAGE_BITS-1:0]) + END_W'(burstcount);
   a_no_page_cross : assert property (@(posedge clk) disable iff (!reset_n)
      enable |-> burst_end <= END_W'(`TG_PAGE_WORDS));

endmodule

/* hw/tg_top.sv */
// Memory traffic generator top
`timescale 1ns/1ps

module tg_top (
   input  logic                clk,
   input  logic                reset_n,

   // Run control
   input  logic                start,
   output logic                busy,
   output logic                done,
   output tg_pkg::err_count_t  error_count,

   // Wishbone classic master
   output logic                wb_cyc,
   output logic                wb_stb,
   output logic                wb_we,
   output tg_pkg::addr_t       wb_adr,
   output tg_pkg::data_t       wb_wdata,
   output logic [3:0]          wb_sel,
   input  tg_pkg::data_t       wb_rdata,
   input  logic                wb_ack
);
   import tg_pkg::*;

   // Burst handoff between the two halves
   logic        next_burst;
   logic        addr_ready;
   addr_t       burst_addr;
   burstcount_t burst_len;

   // Start address and length per burst
   tg_seq_addr_gen u_addr_gen (
      .clk        (clk),
      .reset_n    (reset_n),
      .enable     (next_burst),
      .ready      (addr_ready),
      .addr       (burst_addr),
      .burstcount (burst_len)
   );

   // Write, read back and compare on the bus
   tg_wb_driver u_driver (
      .clk         (clk),
      .reset_n     (reset_n),
      .start       (start),
      .busy        (busy),
      .done        (done),
      .error_count (error_count),
      .next_burst  (next_burst),
      .addr_ready  (addr_ready),
      .burst_addr  (burst_addr),
      .burst_len   (burst_len),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_wdata    (wb_wdata),
      .wb_sel      (wb_sel),
      .wb_rdata    (wb_rdata),
      .wb_ack      (wb_ack)
   );

endmodule

/* hw/tg_wb_driver.sv */
// Wishbone classic burst driver
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_wb_driver (
   input  logic                 clk,
   input  logic                 reset_n,

   // Run control
   input  logic                 start,
   output logic                 busy,
   output logic                 done,
   output tg_pkg::err_count_t   error_count,

   // Address generator side
   output logic                 next_burst,
   input  logic                 addr_ready,
   input  tg_pkg::addr_t        burst_addr,
   input  tg_pkg::burstcount_t  burst_len,

   // Wishbone classic master
   output logic                 wb_cyc,
   output logic                 wb_stb,
   output logic                 wb_we,
   output tg_pkg::addr_t        wb_adr,
   output tg_pkg::data_t        wb_wdata,
   output logic [3:0]           wb_sel,
   input  tg_pkg::data_t        wb_rdata,
   input  logic                 wb_ack
);
   import tg_pkg::*;

   localparam int BURST_CNT_W = $clog2(`TG_NUM_BURSTS + 1);

   drv_state_t             state;
   logic [BURST_CNT_W-1:0] burst_cnt;
   burstcount_t            beat_idx;
   addr_t                  cur_addr;
   burstcount_t            cur_len;

   logic beat_start;
   logic beat_done;
   logic last_beat;
   logic last_burst;
   logic rd_mismatch;

   // Upper half is the address and lower half its inverse
   function automatic data_t pattern(input addr_t a);
      return {a, ~a};
   endfunction

   ////////////////////////////////////////////////////////////////////
   // Beat handshake
   ////////////////////////////////////////////////////////////////////

   // Strobe low in a data phase means a new beat goes out
   assign beat_start  = ((state == WRITE) || (state == READ)) && !wb_stb;
   assign beat_done   = wb_stb && wb_ack;
   assign last_beat   = beat_idx == (cur_len - burstcount_t'(1));
   assign last_burst  = burst_cnt == BURST_CNT_W'(`TG_NUM_BURSTS - 1);
   assign rd_mismatch = wb_rdata != pattern(wb_adr);

   assign next_burst = (state == FETCH) && addr_ready;
   assign busy       = state != IDLE;
   assign done       = state == DONE;
   assign wb_wdata   = pattern(wb_adr);
   assign wb_sel     = '1;

   ////////////////////////////////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state       <= IDLE;
         burst_cnt   <= '0;
         beat_idx    <= '0;
         wb_cyc      <= 1'b0;
         wb_stb      <= 1'b0;
         wb_we       <= 1'b0;
         error_count <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               // start outside IDLE is dropped
               if (start)
               begin
                  burst_cnt <= '0;
                  state     <= FETCH;
               end
            end
            FETCH:
            begin
               // Burst taken this cycle
               if (addr_ready)
               begin
                  beat_idx <= '0;
                  state    <= WRITE;
               end
            end
            WRITE, READ:
            begin
               if (beat_start)
               begin
                  wb_cyc <= 1'b1;
                  wb_stb <= 1'b1;
                  wb_we  <= (state == WRITE);
               end
               else if (beat_done)
               begin
                  // One idle strobe cycle between beats
                  wb_stb <= 1'b0;
                  if ((state == READ) && rd_mismatch && (error_count != '1))
                     error_count <= error_count + err_count_t'(1);
                  if (last_beat)
                  begin
                     wb_cyc   <= 1'b0;
                     beat_idx <= '0;
                     if (state == WRITE)
                        state <= READ;
                     else if (last_burst)
                        state <= DONE;
                     else
                     begin
                        burst_cnt <= burst_cnt + 1'b1;
                        state     <= FETCH;
                     end
                  end
                  else
                     beat_idx <= beat_idx + burstcount_t'(1);
               end
            end
            DONE:
               state <= IDLE;
            default:
               state <= IDLE;
         endcase
      end
   end

   // Burst parameters and bus address
   always_ff @(posedge clk)
   begin
      if (next_burst)
      begin
         cur_addr <= burst_addr;
         cur_len  <= burst_len;
      end
      if (beat_start)
         wb_adr <= cur_addr + addr_t'(beat_idx);
   end

   // Strobe only inside a cycle
   a_stb_in_cyc : assert property (@(posedge clk) disable iff (!reset_n)
      wb_stb |-> wb_cyc);

   // Request held steady under back-pressure
   a_hold_until_ack : assert property (@(posedge clk) disable iff (!reset_n)
      (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_we));

endmodule

/* include/tg_config.svh */
// Traffic generator configuration
`ifndef TG_CONFIG_SVH
`define TG_CONFIG_SVH

// Bus widths in word addressing
`define TG_ADDR_WIDTH        16
`define TG_DATA_WIDTH        32

// Burst length field
`define TG_BURSTCOUNT_WIDTH  4

// Inclusive burst length range
// Range size (max - min + 1) must be a power of two
`define TG_MIN_BURSTCOUNT    1
`define TG_MAX_BURSTCOUNT    8

// Page size in words as a power of two
// A burst is never allowed to straddle two pages
`define TG_PAGE_WORDS        64

// Bursts issued per start pulse
`define TG_NUM_BURSTS        12

// Nonzero LFSR reset value
`define TG_LFSR_SEED         16'hACE1

`endif

/* src.f */
+incdir+include
hw/tg_pkg.sv
hw/tg_rand_burstcount_gen.sv
hw/tg_page_boundary_addr_gen.sv
hw/tg_seq_addr_gen.sv
hw/tg_wb_driver.sv
hw/tg_top.sv
tb/tb_wb_mem.sv
tb/tb_tg.sv

/* tb/tb_tg.sv */
// Traffic generator testbench
`timescale 1ns/1ps
`include "tg_config.svh"

module tb_tg;
   import tg_pkg::*;

   localparam int PAGE_BITS = $clog2(`TG_PAGE_WORDS);
   localparam int TIMEOUT_CYCLES =
      3 * `TG_NUM_BURSTS * `TG_MAX_BURSTCOUNT * 2 * 5 + 1000;

   logic clk;
   logic reset_n;
   logic start;
   logic busy;
   logic done;
   err_count_t error_count;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic wb_ack;
   logic [3:0] wb_sel;
   addr_t wb_adr;
   data_t wb_wdata;
   data_t wb_rdata;
   logic fault_arm;
   addr_t fault_addr;

   // Reference model state
   logic [15:0] m_lfsr;
   addr_t m_next;
   // Monitor state
   addr_t wr_adr[$];
   addr_t rd_adr[$];
   addr_t burst_adr[$];
   data_t wr_data[$];
   logic prev_cyc;
   logic phase_we;
   int run_bursts = 0;
   int relocated = 0;
   int checks = 0;
   int errors = 0;
   int cycles = 0;

   tg_top DUT (.clk(clk), .reset_n(reset_n), .start(start), .busy(busy), .done(done),
      .error_count(error_count), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_sel(wb_sel), .wb_rdata(wb_rdata),
      .wb_ack(wb_ack));

   tb_wb_mem u_mem (.clk(clk), .reset_n(reset_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
      .wb_we(wb_we), .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_sel(wb_sel),
      .wb_rdata(wb_rdata), .wb_ack(wb_ack), .fault_arm(fault_arm),
      .fault_addr(fault_addr));

   always #50 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Galois form shifting right with taps B400
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
   endfunction

   function automatic burstcount_t model_len(input logic [15:0] s);
      return burstcount_t'(`TG_MIN_BURSTCOUNT + int'(s[2:0]));
   endfunction

   // Straddling start moves to the next page base
   function automatic addr_t model_start(input addr_t prop, input burstcount_t len);
      int offset;
      offset = int'(prop) % `TG_PAGE_WORDS;
      if (offset + int'(len) > `TG_PAGE_WORDS)
         return addr_t'(int'(prop) - offset + `TG_PAGE_WORDS);
      return prop;
   endfunction

   function automatic data_t addr_pattern(input addr_t a);
      return {a, ~a};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic report(input string what, input bit bad, input string detail);
      checks++;
      if (bad)
      begin
         errors++;
         $display("[ERROR] %0t: %s, %s", $time, what, detail);
      end
   endtask

   task automatic check_addr(input string what, input addr_t got, input addr_t exp);
      report(what, got !== exp, $sformatf("got %h expected %h", got, exp));
   endtask

   task automatic check_len(input string what, input burstcount_t got,
                            input burstcount_t exp);
      report(what, got !== exp, $sformatf("got %0d expected %0d", got, exp));
   endtask

   task automatic check_data(input string what, input data_t got, input data_t exp);
      report(what, got !== exp, $sformatf("got %h expected %h", got, exp));
   endtask

   task automatic check_errors(input string what, input err_count_t got,
                               input err_count_t exp);
      report(what, got !== exp, $sformatf("got %0d expected %0d", got, exp));
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      report(what, got !== exp, $sformatf("got %b expected %b", got, exp));
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      report(what, got != exp, $sformatf("got %0d expected %0d", got, exp));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Bus monitor
   //////////////////////////////////////////////////////////////////////

   // Compare a closed write phase against the next modelled burst
   task automatic close_write_phase();
      burstcount_t exp_len;
      addr_t exp_start;
      addr_t exp_a;
      int n;
      exp_len = model_len(m_lfsr);
      exp_start = model_start(m_next, exp_len);
      if (exp_start != m_next)
         relocated++;
      n = wr_adr.size();
      check_len("burst length", burstcount_t'(n), exp_len);
      check_flag("burst length in range",
                 (n >= `TG_MIN_BURSTCOUNT) && (n <= `TG_MAX_BURSTCOUNT), 1'b1);
      if (n > 0)
      begin
         check_addr("burst start", wr_adr[0], exp_start);
         check_flag("burst inside one page",
                    (wr_adr[0] >> PAGE_BITS) == (wr_adr[n-1] >> PAGE_BITS), 1'b1);
      end
      for (int i = 0; i < n; i++)
      begin
         exp_a = exp_start + addr_t'(i);
         check_addr("write beat address", wr_adr[i], exp_a);
         check_data("write data", wr_data[i], addr_pattern(exp_a));
      end
      burst_adr = wr_adr;
      wr_adr.delete();
      wr_data.delete();
      // Advance the model by one accepted burst
      m_next = exp_start + addr_t'(exp_len);
      m_lfsr = lfsr_step(m_lfsr);
      run_bursts++;
   endtask

   // Readback covers the same words in the same order
   task automatic close_read_phase();
      check_count("read beats", rd_adr.size(), burst_adr.size());
      for (int i = 0; (i < rd_adr.size()) && (i < burst_adr.size()); i++)
         check_addr("read beat address", rd_adr[i], burst_adr[i]);
      rd_adr.delete();
   endtask

   // Sampled mid-cycle away from the driving edge
   always @(negedge clk)
   begin
      if (!reset_n)
         prev_cyc = 1'b0;
      else
      begin
         if (wb_cyc && wb_stb && wb_ack)
         begin
            check_flag("wb_sel all ones", wb_sel == 4'hF, 1'b1);
            phase_we = wb_we;
            if (wb_we)
            begin
               wr_adr.push_back(wb_adr);
               wr_data.push_back(wb_wdata);
            end
            else
               rd_adr.push_back(wb_adr);
         end
         // Phase ends at a wb_cyc drop
         if (prev_cyc && !wb_cyc)
         begin
            if (phase_we)
               close_write_phase();
            else
               close_read_phase();
         end
         prev_cyc = wb_cyc;
      end
   end

   // Watchdog
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: runs did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Something failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   // One run with a stray start pulse while busy
   task automatic run_traffic(input err_count_t exp_err);
      int gap;
      gap = $urandom_range(8, 1);
      repeat (gap) @(posedge clk);
      #1 start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
      gap = $urandom_range(12, 2);
      repeat (gap) @(posedge clk);
      #1;
      check_flag("busy before stray start", busy, 1'b1);
      start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
      do
         @(negedge clk);
      while (!done);
      check_errors("error count at done", error_count, exp_err);
      check_count("bursts in run", run_bursts, `TG_NUM_BURSTS);
      run_bursts = 0;
   endtask

   initial
   begin
      void'($urandom(32'h896d9626));
      clk = 1'b0;
      reset_n = 1'b0;
      start = 1'b0;
      fault_arm = 1'b0;
      fault_addr = '0;
      m_lfsr = `TG_LFSR_SEED;
      m_next = '0;
      repeat (4) @(posedge clk);
      #1 reset_n = 1'b1;
      @(negedge clk);
      check_flag("busy after reset", busy, 1'b0);
      check_flag("done after reset", done, 1'b0);
      check_flag("wb_cyc after reset", wb_cyc, 1'b0);
      check_errors("error count after reset", error_count, '0);
      run_traffic(err_count_t'(0));
      run_traffic(err_count_t'(0));
      // Corrupt the first modelled word of run 3
      fault_addr = model_start(m_next, model_len(m_lfsr));
      fault_arm = 1'b1;
      run_traffic(err_count_t'(1));
      // At least one burst has to be moved to a page base
      check_flag("page move seen", relocated > 0, 1'b1);
      $display("Checks %0d, errors %0d, page moves %0d", checks, errors, relocated);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* tb/tb_wb_mem.sv */
// Wishbone classic memory model
`timescale 1ns/1ps
`include "tg_config.svh"

module tb_wb_mem (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  tg_pkg::addr_t       wb_adr,
   input  tg_pkg::data_t       wb_wdata,
   input  logic [3:0]          wb_sel,
   output tg_pkg::data_t       wb_rdata,
   output logic                wb_ack,
   // One-shot read corruption
   input  logic                fault_arm,
   input  tg_pkg::addr_t       fault_addr
);
   import tg_pkg::*;

   localparam int MEM_WORDS = 1 << `TG_ADDR_WIDTH;

   data_t       mem [0:MEM_WORDS-1];
   logic        pending;
   logic [1:0]  wait_left;
   logic        fired;

   // Fill differs from the write pattern at every address
   initial
   begin
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = {~addr_t'(i), addr_t'(i)};
   end

   // 0 to 3 wait states per beat and a one-cycle ack
   always @(posedge clk or negedge reset_n)
   begin : respond
      logic       go;
      logic [1:0] draw;
      data_t      merged;
      if (!reset_n)
      begin
         wb_ack    <= 1'b0;
         wb_rdata  <= '0;
         pending   <= 1'b0;
         wait_left <= '0;
         fired     <= 1'b0;
      end
      else
      begin
         go = 1'b0;
         wb_ack <= 1'b0;
         if (wb_cyc && wb_stb && !wb_ack)
         begin
            if (!pending)
            begin
               // New request picks its stall length
               draw = 2'($urandom_range(3, 0));
               if (draw == 2'd0)
                  go = 1'b1;
               else
               begin
                  pending   <= 1'b1;
                  wait_left <= draw - 2'd1;
               end
            end
            else if (wait_left != 2'd0)
               wait_left <= wait_left - 2'd1;
            else
            begin
               pending <= 1'b0;
               go = 1'b1;
            end
         end
         if (go)
         begin
            wb_ack <= 1'b1;
            if (wb_we)
            begin
               // Only the byte lanes enabled by wb_sel change
               merged = mem[wb_adr];
               for (int b = 0; b < 4; b++)
                  if (wb_sel[b])
                     merged[8*b +: 8] = wb_wdata[8*b +: 8];
               mem[wb_adr] <= merged;
            end
            else if (fault_arm && !fired && (wb_adr == fault_addr))
            begin
               // Single flipped bit on the first match only
               wb_rdata <= mem[wb_adr] ^ data_t'(1);
               fired    <= 1'b1;
            end
            else
               wb_rdata <= mem[wb_adr];
         end
      end
   end

endmodule
